/* hdl/mipsDecodePkg.sv */
package mipsDecodePkg;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opRegImm  = 6'h01;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opBlez    = 6'h06;
    localparam logic [5:0] opBgtz    = 6'h07;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opXori    = 6'h0e;
    localparam logic [5:0] opLb      = 6'h20;
    localparam logic [5:0] opLh      = 6'h21;
    localparam logic [5:0] opLwl     = 6'h22;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opLbu     = 6'h24;
    localparam logic [5:0] opLhu     = 6'h25;
    localparam logic [5:0] opLwr     = 6'h26;
    localparam logic [5:0] opSb      = 6'h28;
    localparam logic [5:0] opSh      = 6'h29;
    localparam logic [5:0] opSw      = 6'h2b;

    // SPECIAL funct codes
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnJalr = 6'h09;
    localparam logic [5:0] fnMfhi = 6'h10;
    localparam logic [5:0] fnMthi = 6'h11;
    localparam logic [5:0] fnMflo = 6'h12;
    localparam logic [5:0] fnMtlo = 6'h13;

    // REGIMM rt codes of the linking branches
    localparam logic [5:0] rtBltzal = 6'h10;
    localparam logic [5:0] rtBgezal = 6'h11;

    localparam logic [4:0] linkReg = 5'd31;

    typedef enum logic [1:0] {
        regDstRt   = 2'd0,
        regDstRd   = 2'd1,
        regDstLink = 2'd2
    } regDst_e;

    typedef enum logic [2:0] {
        memToRegAlu = 3'd0,
        memToRegMem = 3'd1,
        memToRegPc4 = 3'd2,
        memToRegHi  = 3'd3,
        memToRegLo  = 3'd4
    } memToReg_e;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rInstr_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iInstr_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jInstr_t;

    // One instruction word in three field layouts
    typedef union packed {
        rInstr_t r;
        iInstr_t i;
        jInstr_t j;
    } mipsInstr_u;

    typedef struct packed {
        logic      jr;
        logic      jump;
        logic [1:0] regWrite;   // Bit 1 is the upper halfword and bit 0 the lower
        logic      memRead;
        logic      memWrite;
        regDst_e   regDst;
        memToReg_e memToReg;
        logic [1:0] hiWrite;
        logic [1:0] loWrite;
        logic      delayEarly;
    } ctrlSignals_t;

    typedef struct packed {
        logic [31:0] pc;
        mipsInstr_u  instr;
    } fetchPacket_t;

    typedef struct packed {
        ctrlSignals_t ctrl;
        logic [31:0]  pcPlus4;
        logic [31:0]  jumpTarget;
        logic [31:0]  rsValue;
        logic [31:0]  rtValue;
        logic [31:0]  hiValue;
        logic [31:0]  loValue;
        logic [31:0]  immExt;
        logic [4:0]   destReg;
        mipsInstr_u   instr;
    } decodedPacket_t;

    typedef struct packed {
        logic [1:0]  regWrite;
        logic [4:0]  destReg;
        logic [31:0] value;
        logic [1:0]  hiWrite;
        logic [1:0]  loWrite;
        logic [31:0] hiValue;
        logic [31:0] loValue;
    } writeback_t;

endpackage

/* hdl/controlUnit.sv */
module controlUnit
    import mipsDecodePkg::*;
(
    input  mipsInstr_u   instr,
    output ctrlSignals_t ctrl
);

    always_comb
    begin
        // Everything off unless an opcode says otherwise
        ctrl          = '0;
        ctrl.regDst   = regDstRt;
        ctrl.memToReg = memToRegAlu;

        case (instr.r.opcode)
            opSpecial:
            begin
                ctrl.regDst = regDstRd;
                case (instr.r.funct)
                    fnJr:
                    begin
                        ctrl.jr         = 1'b1;
                        ctrl.delayEarly = 1'b1;
                    end
                    fnJalr:
                    begin
                        ctrl.jr         = 1'b1;
                        ctrl.delayEarly = 1'b1;
                        ctrl.memToReg   = memToRegPc4;
                        ctrl.regWrite   = 2'b11;
                    end
                    fnMthi:
                    begin
                        ctrl.hiWrite = 2'b11;
                    end
                    fnMtlo:
                    begin
                        ctrl.loWrite = 2'b11;
                    end
                    fnMfhi:
                    begin
                        ctrl.memToReg = memToRegHi;
                        ctrl.regWrite = 2'b11;
                    end
                    fnMflo:
                    begin
                        ctrl.memToReg = memToRegLo;
                        ctrl.regWrite = 2'b11;
                    end
                    // Plain ALU ops write rd
                    default:
                    begin
                        ctrl.regWrite = 2'b11;
                    end
                endcase
            end

            opJ:
            begin
                ctrl.jump       = 1'b1;
                ctrl.delayEarly = 1'b1;
            end

            opJal:
            begin
                ctrl.jump       = 1'b1;
                ctrl.delayEarly = 1'b1;
                ctrl.regDst     = regDstLink;
                ctrl.memToReg   = memToRegPc4;
                ctrl.regWrite   = 2'b11;
            end

            opBeq, opBne, opBlez, opBgtz:
            begin
                ctrl.delayEarly = 1'b1;
            end

            opRegImm:
            begin
                ctrl.delayEarly = 1'b1;
                // Only the AL forms save a return address
                if ({1'b0, instr.i.rt} == rtBltzal || {1'b0, instr.i.rt} == rtBgezal)
                begin
                    ctrl.regDst   = regDstLink;
                    ctrl.memToReg = memToRegPc4;
                    ctrl.regWrite = 2'b11;
                end
            end

            opSb, opSh, opSw:
            begin
                ctrl.memWrite = 1'b1;
            end

            // Unaligned loads merge into one half of rt
            opLwl:
            begin
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = memToRegMem;
                ctrl.regWrite = 2'b10;
            end

            opLwr:
            begin
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = memToRegMem;
                ctrl.regWrite = 2'b01;
            end

            opLb, opLh, opLw, opLbu, opLhu:
            begin
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = memToRegMem;
                ctrl.regWrite = 2'b11;
            end

            // Immediate ALU ops and anything unlisted write rt
            default:
            begin
                ctrl.regWrite = 2'b11;
            end
        endcase
    end

endmodule

/* hdl/registerBank.sv */
module registerBank
    import mipsDecodePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  writeback_t  wb,
    output logic [31:0] rsValue,
    output logic [31:0] rtValue,
    output logic [31:0] hiValue,
    output logic [31:0] loValue
);

    logic [31:0] regs [32];
    logic [31:0] hiReg;
    logic [31:0] loReg;

    // Replace only the halfwords whose lane bit is set
    function automatic logic [31:0] laneMerge(
        input logic [31:0] oldValue,
        input logic [31:0] newValue,
        input logic [1:0]  lanes
    );
        return {lanes[1] ? newValue[31:16] : oldValue[31:16],
                lanes[0] ? newValue[15:0]  : oldValue[15:0]};
    endfunction

    // Reads see a same-cycle write
    always_comb
    begin
        rsValue = '0;
        rtValue = '0;
        if (rsAddr != 5'd0)
            rsValue = laneMerge(regs[rsAddr], wb.value,
                                (rsAddr == wb.destReg) ? wb.regWrite : 2'b00);
        if (rtAddr != 5'd0)
            rtValue = laneMerge(regs[rtAddr], wb.value,
                                (rtAddr == wb.destReg) ? wb.regWrite : 2'b00);
    end

    assign hiValue = laneMerge(hiReg, wb.hiValue, wb.hiWrite);
    assign loValue = laneMerge(loReg, wb.loValue, wb.loWrite);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
            hiReg <= '0;
            loReg <= '0;
        end
        else
        begin
            // Register 0 stays zero
            if (wb.destReg != 5'd0)
                regs[wb.destReg] <= laneMerge(regs[wb.destReg], wb.value, wb.regWrite);
            hiReg <= hiValue;
            loReg <= loValue;
        end
    end

endmodule

/* hdl/decodeStage.sv */
module decodeStage
    import mipsDecodePkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           inValid,
    output logic           inReady,
    input  fetchPacket_t   inPacket,
    input  ctrlSignals_t   ctrl,
    input  logic [31:0]    rsValue,
    input  logic [31:0]    rtValue,
    input  logic [31:0]    hiValue,
    input  logic [31:0]    loValue,
    output logic           outValid,
    input  logic           outReady,
    output decodedPacket_t outPacket
);

    logic           accept;
    logic [31:0]    pcPlus4;
    decodedPacket_t nextPacket;

    // Slot frees up when empty or when the held packet leaves this edge
    assign inReady = !outValid || outReady;
    assign accept  = inValid && inReady;

    assign pcPlus4 = inPacket.pc + 32'd4;

    always_comb
    begin
        nextPacket.ctrl       = ctrl;
        nextPacket.pcPlus4    = pcPlus4;
        nextPacket.jumpTarget = {pcPlus4[31:28], inPacket.instr.j.target, 2'b00};
        nextPacket.rsValue    = rsValue;
        nextPacket.rtValue    = rtValue;
        nextPacket.hiValue    = hiValue;
        nextPacket.loValue    = loValue;
        nextPacket.instr      = inPacket.instr;

        // Logical immediates are zero extended
        case (inPacket.instr.i.opcode)
            opAndi, opOri, opXori:
                nextPacket.immExt = {16'h0000, inPacket.instr.i.imm};
            default:
                nextPacket.immExt = {{16{inPacket.instr.i.imm[15]}}, inPacket.instr.i.imm};
        endcase

        case (ctrl.regDst)
            regDstRd:
                nextPacket.destReg = inPacket.instr.r.rd;
            regDstLink:
                nextPacket.destReg = linkReg;
            default:
                nextPacket.destReg = inPacket.instr.i.rt;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            outValid <= 1'b0;
        else if (accept)
            outValid <= 1'b1;
        else if (outReady)
            outValid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            outPacket <= nextPacket;
    end

endmodule

/* hdl/mipsDecodeTop.sv */
module mipsDecodeTop
    import mipsDecodePkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           inValid,
    output logic           inReady,
    input  fetchPacket_t   inPacket,
    output logic           outValid,
    input  logic           outReady,
    output decodedPacket_t outPacket,
    input  writeback_t     wb
);

    ctrlSignals_t ctrl;
    logic [31:0]  rsValue;
    logic [31:0]  rtValue;
    logic [31:0]  hiValue;
    logic [31:0]  loValue;

    controlUnit u_controlUnit (
        .instr (inPacket.instr),
        .ctrl  (ctrl)
    );

    // Operands read straight from the incoming instruction
    registerBank u_registerBank (
        .clk     (clk),
        .rst     (rst),
        .rsAddr  (inPacket.instr.r.rs),
        .rtAddr  (inPacket.instr.r.rt),
        .wb      (wb),
        .rsValue (rsValue),
        .rtValue (rtValue),
        .hiValue (hiValue),
        .loValue (loValue)
    );

    decodeStage u_decodeStage (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .inReady   (inReady),
        .inPacket  (inPacket),
        .ctrl      (ctrl),
        .rsValue   (rsValue),
        .rtValue   (rtValue),
        .hiValue   (hiValue),
        .loValue   (loValue),
        .outValid  (outValid),
        .outReady  (outReady),
        .outPacket (outPacket)
    );

endmodule

/* tests/mipsDecodeTop_properties.sv */
module mipsDecodeProps
    import mipsDecodePkg::*;
(
    input logic           clk,
    input logic           rst,
    input logic           inReady,
    input logic           outValid,
    input logic           outReady,
    input decodedPacket_t outPacket
);

    int failCount = 0;

    // Stage empties on reset
    assert property (@(posedge clk) rst |=> !outValid)
        else
        begin
            failCount++;
            $error("outValid high in the cycle after reset");
        end

    // Held output under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable(outPacket)))
        else
        begin
            failCount++;
            $error("Output changed while stalled");
        end

    assert property (@(posedge clk) disable iff (rst)
        inReady == (!outValid || outReady))
        else
        begin
            failCount++;
            $error("inReady does not follow outValid and outReady");
        end

endmodule

bind mipsDecodeTop mipsDecodeProps u_mipsDecodeProps (
    .clk       (clk),
    .rst       (rst),
    .inReady   (inReady),
    .outValid  (outValid),
    .outReady  (outReady),
    .outPacket (outPacket)
);

/* tests/mipsDecodeTb.sv */
module mipsDecodeTb
    import mipsDecodePkg::*;
();

    localparam int timeoutCycles = 20;

    logic           clk;
    logic           rst;
    logic           inValid;
    logic           inReady;
    fetchPacket_t   inPacket;
    logic           outValid;
    logic           outReady;
    decodedPacket_t outPacket;
    writeback_t     wb;

    mipsDecodeTop u_mipsDecodeTop (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .inReady   (inReady),
        .inPacket  (inPacket),
        .outValid  (outValid),
        .outReady  (outReady),
        .outPacket (outPacket),
        .wb        (wb)
    );

    always #4 clk = ~clk;

    task automatic checkValue(input string testName, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("MISMATCH %s %s expected %h actual %h", testName, field, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timed out waiting for %s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] funct);
        return {opSpecial, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // One cycle of writeback, then the port goes idle
    task automatic writeReg(input logic [4:0] addr, input logic [31:0] value,
                            input logic [1:0] lanes);
        @(posedge clk);
        wb.regWrite <= lanes;
        wb.destReg  <= addr;
        wb.value    <= value;
        @(posedge clk);
        wb <= '0;
    endtask

    task automatic writeHiLo(input logic [31:0] hi, input logic [31:0] lo);
        @(posedge clk);
        wb.hiWrite <= 2'b11;
        wb.loWrite <= 2'b11;
        wb.hiValue <= hi;
        wb.loValue <= lo;
        @(posedge clk);
        wb <= '0;
    endtask

    // Returns on the edge where the offered packet is taken
    task automatic waitAccept();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!inReady)
        begin
            cycles++;
            if (cycles > timeoutCycles)
                timeoutFail("inReady");
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic waitOutput();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!outValid)
        begin
            cycles++;
            if (cycles > timeoutCycles)
                timeoutFail("outValid");
            @(negedge clk);
        end
    endtask

    task automatic decodeInstr(input logic [31:0] pc, input logic [31:0] instr,
                               output decodedPacket_t got);
        @(posedge clk);
        inValid        <= 1'b1;
        inPacket.pc    <= pc;
        inPacket.instr <= instr;
        waitAccept();
        inValid <= 1'b0;
        waitOutput();
        got = outPacket;
    endtask

    task automatic resetAndRtype();
        decodedPacket_t got;
        logic [31:0]    a;
        logic [31:0]    b;
        a = $urandom();
        b = $urandom();
        @(negedge clk);
        checkValue("reset", "outValid", 32'd0, outValid);
        checkValue("reset", "inReady", 32'd1, inReady);
        writeReg(5'd5, a, 2'b11);
        writeReg(5'd6, b, 2'b11);
        decodeInstr(32'h0040_0000, rType(5'd5, 5'd6, 5'd7, 6'h20), got);
        checkValue("add", "rsValue", a, got.rsValue);
        checkValue("add", "rtValue", b, got.rtValue);
        checkValue("add", "destReg", 32'd7, got.destReg);
        checkValue("add", "regDst", regDstRd, got.ctrl.regDst);
        checkValue("add", "regWrite", 32'd3, got.ctrl.regWrite);
        checkValue("add", "memToReg", memToRegAlu, got.ctrl.memToReg);
        // Register 0 ignores writes
        writeReg(5'd0, $urandom(), 2'b11);
        decodeInstr(32'h0040_0004, rType(5'd0, 5'd5, 5'd7, 6'h20), got);
        checkValue("addZero", "rsValue", 32'd0, got.rsValue);
    endtask

    task automatic loadsAndStores();
        decodedPacket_t got;
        decodeInstr(32'h0040_0100, iType(opLw, 5'd8, 5'd9, 16'hfff0), got);
        checkValue("lw", "memRead", 32'd1, got.ctrl.memRead);
        checkValue("lw", "memToReg", memToRegMem, got.ctrl.memToReg);
        checkValue("lw", "destReg", 32'd9, got.destReg);
        checkValue("lw", "immExt", 32'hffff_fff0, got.immExt);
        decodeInstr(32'h0040_0104, iType(opOri, 5'd8, 5'd9, 16'h8001), got);
        checkValue("ori", "immExt", 32'h0000_8001, got.immExt);
        checkValue("ori", "regWrite", 32'd3, got.ctrl.regWrite);
        decodeInstr(32'h0040_0108, iType(opSw, 5'd8, 5'd9, 16'h0004), got);
        checkValue("sw", "memWrite", 32'd1, got.ctrl.memWrite);
        checkValue("sw", "regWrite", 32'd0, got.ctrl.regWrite);
        decodeInstr(32'h0040_010c, iType(opLwl, 5'd8, 5'd9, 16'h0003), got);
        checkValue("lwl", "regWrite", 32'd2, got.ctrl.regWrite);
        decodeInstr(32'h0040_0110, iType(opLwr, 5'd8, 5'd9, 16'h0000), got);
        checkValue("lwr", "regWrite", 32'd1, got.ctrl.regWrite);
        // Lower lane only
        writeReg(5'd10, 32'h1111_2222, 2'b11);
        writeReg(5'd10, 32'haaaa_bbbb, 2'b01);
        decodeInstr(32'h0040_0114, rType(5'd10, 5'd0, 5'd11, 6'h20), got);
        checkValue("laneWrite", "rsValue", 32'h1111_bbbb, got.rsValue);
    endtask

    task automatic jumpsAndBranches();
        decodedPacket_t got;
        logic [31:0]    pc;
        logic [25:0]    target;
        logic [31:0]    pc4;
        pc     = $urandom() & 32'hffff_fffc;
        target = $urandom();
        pc4    = pc + 32'd4;
        decodeInstr(pc, {opJal, target}, got);
        checkValue("jal", "jump", 32'd1, got.ctrl.jump);
        checkValue("jal", "delayEarly", 32'd1, got.ctrl.delayEarly);
        checkValue("jal", "destReg", 32'd31, got.destReg);
        checkValue("jal", "memToReg", memToRegPc4, got.ctrl.memToReg);
        checkValue("jal", "pcPlus4", pc4, got.pcPlus4);
        checkValue("jal", "jumpTarget", {pc4[31:28], target, 2'b00}, got.jumpTarget);
        decodeInstr(32'h0040_0200, rType(5'd8, 5'd0, 5'd0, fnJr), got);
        checkValue("jr", "jr", 32'd1, got.ctrl.jr);
        checkValue("jr", "regWrite", 32'd0, got.ctrl.regWrite);
        decodeInstr(32'h0040_0204, iType(opBeq, 5'd1, 5'd2, 16'h0010), got);
        checkValue("beq", "delayEarly", 32'd1, got.ctrl.delayEarly);
        checkValue("beq", "jump", 32'd0, got.ctrl.jump);
        checkValue("beq", "jr", 32'd0, got.ctrl.jr);
        checkValue("beq", "regWrite", 32'd0, got.ctrl.regWrite);
        checkValue("beq", "memWrite", 32'd0, got.ctrl.memWrite);
        decodeInstr(32'h0040_0208, iType(opRegImm, 5'd3, rtBgezal[4:0], 16'h0020), got);
        checkValue("bgezal", "destReg", 32'd31, got.destReg);
        checkValue("bgezal", "regWrite", 32'd3, got.ctrl.regWrite);
    endtask

    task automatic hiLoMoves();
        decodedPacket_t got;
        logic [31:0]    hi;
        logic [31:0]    lo;
        hi = $urandom();
        lo = $urandom();
        decodeInstr(32'h0040_0280, rType(5'd8, 5'd0, 5'd0, fnMthi), got);
        checkValue("mthi", "hiWrite", 32'd3, got.ctrl.hiWrite);
        checkValue("mthi", "loWrite", 32'd0, got.ctrl.loWrite);
        checkValue("mthi", "regWrite", 32'd0, got.ctrl.regWrite);
        decodeInstr(32'h0040_0284, rType(5'd8, 5'd0, 5'd0, fnMtlo), got);
        checkValue("mtlo", "loWrite", 32'd3, got.ctrl.loWrite);
        checkValue("mtlo", "hiWrite", 32'd0, got.ctrl.hiWrite);
        checkValue("mtlo", "regWrite", 32'd0, got.ctrl.regWrite);
        writeHiLo(hi, lo);
        decodeInstr(32'h0040_0288, rType(5'd0, 5'd0, 5'd12, fnMfhi), got);
        checkValue("mfhi", "hiValue", hi, got.hiValue);
        checkValue("mfhi", "loValue", lo, got.loValue);
        checkValue("mfhi", "memToReg", memToRegHi, got.ctrl.memToReg);
        checkValue("mfhi", "destReg", 32'd12, got.destReg);
    endtask

    task automatic backPressure();
        decodedPacket_t got;
        logic [31:0]    firstInstr;
        logic [31:0]    secondInstr;
        logic [31:0]    a;
        int             cycles;
        a           = $urandom();
        firstInstr  = rType(5'd13, 5'd0, 5'd14, 6'h20);
        secondInstr = iType(opOri, 5'd13, 5'd15, 16'h1234);
        writeReg(5'd13, a, 2'b11);
        @(posedge clk);
        outReady       <= 1'b0;
        inValid        <= 1'b1;
        inPacket.pc    <= 32'h0040_0300;
        inPacket.instr <= firstInstr;
        waitAccept();
        inPacket.pc    <= 32'h0040_0304;
        inPacket.instr <= secondInstr;
        waitOutput();
        // Slot full so nothing moves
        for (cycles = 0; cycles < 3; cycles++)
        begin
            checkValue("stall", "inReady", 32'd0, inReady);
            checkValue("stall", "outValid", 32'd1, outValid);
            checkValue("stall", "instr", firstInstr, outPacket.instr);
            @(negedge clk);
        end
        @(posedge clk);
        outReady <= 1'b1;
        @(negedge clk);
        got = outPacket;
        checkValue("drainFirst", "instr", firstInstr, got.instr);
        checkValue("drainFirst", "rsValue", a, got.rsValue);
        checkValue("drainFirst", "destReg", 32'd14, got.destReg);
        @(posedge clk);
        inValid <= 1'b0;
        waitOutput();
        got = outPacket;
        checkValue("drainSecond", "instr", secondInstr, got.instr);
        checkValue("drainSecond", "rsValue", a, got.rsValue);
        checkValue("drainSecond", "destReg", 32'd15, got.destReg);
        checkValue("drainSecond", "immExt", 32'h0000_1234, got.immExt);
        checkValue("drainSecond", "pcPlus4", 32'h0040_0308, got.pcPlus4);
    endtask

    initial
    begin
        void'($urandom(32'hcc08));
        clk        = 1'b0;
        rst        <= 1'b1;
        inValid    <= 1'b0;
        inPacket   <= '0;
        outReady   <= 1'b1;
        wb         <= '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        resetAndRtype();
        loadsAndStores();
        jumpsAndBranches();
        hiLoMoves();
        backPressure();
        @(posedge clk);
        @(negedge clk);
        if (u_mipsDecodeTop.u_mipsDecodeProps.failCount == 0)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

/* filelist.f */
hdl/mipsDecodePkg.sv
hdl/controlUnit.sv
hdl/registerBank.sv
hdl/decodeStage.sv
hdl/mipsDecodeTop.sv
tests/mipsDecodeTop_properties.sv
tests/mipsDecodeTb.sv

/* Bender.yml */
package:
  name: mips_decode

sources:
  - hdl/mipsDecodePkg.sv
  - hdl/controlUnit.sv
  - hdl/registerBank.sv
  - hdl/decodeStage.sv
  - hdl/mipsDecodeTop.sv
  - target: test
    files:
      - tests/mipsDecodeTop_properties.sv
      - tests/mipsDecodeTb.sv
